//--- rtl/fp_slice_pkg.sv
// Shared definitions for the two-lane non-computational FP slice
// Formats, opcodes, data path widths, canonical NaNs and the status flags
// used by the issue stage, the pipeline and the result packer

`default_nettype none

package fp_slice_pkg;

  // ----------------------------------------
  // Data path geometry
  // ----------------------------------------
  localparam int unsigned SLICE_WIDTH = 32;  // Full data path
  localparam int unsigned NUM_LANES   = 2;
  localparam int unsigned FP16_WIDTH  = 16;  // Width of one FP16 lane slice
  localparam int unsigned AUX_BITS    = 2;   // Vector flag and format

  // ----------------------------------------
  // Formats and operations
  // ----------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic [2:0] {
    OP_SGNJ  = 3'd0,  // Sign taken from b
    OP_SGNJN = 3'd1,  // Inverted sign of b
    OP_SGNJX = 3'd2,  // Xor of both signs
    OP_MIN   = 3'd3,
    OP_MAX   = 3'd4
  } op_e;

  // IEEE 754 exception flags, only NV can be raised by this slice
  typedef struct packed {
    logic NV;  // Invalid operation
    logic DZ;  // Divide by zero
    logic OF;  // Overflow
    logic UF;  // Underflow
    logic NX;  // Inexact
  } status_t;

  // Canonical quiet NaNs
  localparam logic [31:0] QNAN_FP32 = 32'h7FC0_0000;
  localparam logic [15:0] QNAN_FP16 = 16'h7E00;

endpackage

`default_nettype wire

//--- rtl/noncomp_lane.sv
// Non-computational FP unit for one SIMD lane
// Performs sign injection (plain, negated, xor) and IEEE minNum/maxNum
// on FP32 or FP16 operands. Purely combinational. A 16-bit lane only
// handles FP16, a 32-bit lane uses its low half in FP16 mode

`timescale 1ns/1ns
`default_nettype none

module noncomp_lane import fp_slice_pkg::*; #(
  parameter int unsigned LaneWidth = 32
) (
  input  logic [LaneWidth-1:0] a_i,
  input  logic [LaneWidth-1:0] b_i,
  input  op_e                  op_i,
  input  fp_format_e           fmt_i,
  output logic [LaneWidth-1:0] result_o,
  output logic                 nv_o
);

  logic                   is_fp16;
  logic                   is_minmax;
  logic [SLICE_WIDTH-1:0] a_ext;
  logic [SLICE_WIDTH-1:0] b_ext;
  logic [SLICE_WIDTH-1:0] op_a;       // Operands in the active format
  logic [SLICE_WIDTH-1:0] op_b;
  logic                   sign_a;
  logic                   sign_b;
  logic [SLICE_WIDTH-2:0] mag_a;      // Magnitude without sign
  logic [SLICE_WIDTH-2:0] mag_b;
  logic                   nan_a;
  logic                   nan_b;
  logic                   snan_a;
  logic                   snan_b;
  logic [SLICE_WIDTH-1:0] qnan;
  logic                   res_sign;
  logic                   a_lt_b;
  logic [SLICE_WIDTH-1:0] sgnj_res;
  logic [SLICE_WIDTH-1:0] minmax_res;
  logic [SLICE_WIDTH-1:0] full_res;

  assign is_fp16   = (LaneWidth == FP16_WIDTH) || (fmt_i == FP16);
  assign is_minmax = (op_i == OP_MIN) || (op_i == OP_MAX);
  assign a_ext     = SLICE_WIDTH'(a_i);  // Zero extend narrow lanes
  assign b_ext     = SLICE_WIDTH'(b_i);

  // ----------------------------------------
  // Operand classification
  // ----------------------------------------
  always_comb begin : decode
    if (is_fp16) begin
      op_a   = {16'h0, a_ext[15:0]};
      op_b   = {16'h0, b_ext[15:0]};
      sign_a = a_ext[15];
      sign_b = b_ext[15];
      mag_a  = {16'h0, a_ext[14:0]};
      mag_b  = {16'h0, b_ext[14:0]};
      nan_a  = (a_ext[14:10] == '1) && (a_ext[9:0] != '0);
      nan_b  = (b_ext[14:10] == '1) && (b_ext[9:0] != '0);
      snan_a = nan_a && !a_ext[9];   // Quiet bit clear
      snan_b = nan_b && !b_ext[9];
      qnan   = {16'h0, QNAN_FP16};
    end else begin
      op_a   = a_ext;
      op_b   = b_ext;
      sign_a = a_ext[31];
      sign_b = b_ext[31];
      mag_a  = a_ext[30:0];
      mag_b  = b_ext[30:0];
      nan_a  = (a_ext[30:23] == '1) && (a_ext[22:0] != '0);
      nan_b  = (b_ext[30:23] == '1) && (b_ext[22:0] != '0);
      snan_a = nan_a && !a_ext[22];
      snan_b = nan_b && !b_ext[22];
      qnan   = QNAN_FP32;
    end
  end

  // ----------------------------------------
  // Sign injection
  // ----------------------------------------
  always_comb begin : sign_inject
    unique case (op_i)
      OP_SGNJ:  res_sign = sign_b;
      OP_SGNJN: res_sign = ~sign_b;
      OP_SGNJX: res_sign = sign_a ^ sign_b;
      default:  res_sign = sign_a;
    endcase
    sgnj_res = is_fp16 ? {16'h0, res_sign, mag_a[14:0]} : {res_sign, mag_a};
  end

  // ----------------------------------------
  // Min / max
  // ----------------------------------------
  always_comb begin : min_max
    // Sign-magnitude ordering, -0 sorts below +0
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;  // Both negative
    end else begin
      a_lt_b = mag_a < mag_b;
    end

    if (nan_a && nan_b) begin
      minmax_res = qnan;
    end else if (nan_a) begin
      minmax_res = op_b;       // NaN loses against a number
    end else if (nan_b) begin
      minmax_res = op_a;
    end else if ((op_i == OP_MIN) == a_lt_b) begin
      minmax_res = op_a;
    end else begin
      minmax_res = op_b;
    end
  end

  assign full_res = is_minmax ? minmax_res : sgnj_res;
  assign result_o = full_res[LaneWidth-1:0];
  assign nv_o     = is_minmax && (snan_a || snan_b);  // Only signaling NaNs trap

endmodule

`default_nettype wire

//--- rtl/lane_issue.sv
// Issue stage of the SIMD slice
// Splits both operands into lanes, runs the lane units and forms the
// lane-1 activity, the aux bits and the payload for the pipeline

`timescale 1ns/1ns
`default_nettype none

module lane_issue import fp_slice_pkg::*; #(
  parameter int unsigned TagWidth = 4
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [1:0][SLICE_WIDTH-1:0]           operands_i,  // {b, a}
  input  op_e                                   op_i,
  input  fp_format_e                            fmt_i,
  input  logic                                  vectorial_i,
  input  logic [NUM_LANES-1:0]                  simd_mask_i,
  input  logic [TagWidth-1:0]                   tag_i,
  input  logic                                  in_valid_i,
  output logic [NUM_LANES-1:0][SLICE_WIDTH-1:0] lane_result_o,
  output logic [NUM_LANES-1:0]                  lane_nv_o,
  output logic                                  lane1_active_o,
  output logic [AUX_BITS-1:0]                   aux_o,
  output logic [TagWidth-1:0]                   tag_o,
  output logic [NUM_LANES-1:0]                  mask_o,
  output logic                                  valid_o
);

  logic [FP16_WIDTH-1:0] lane1_res;

  // Upper lane only works for vectorial FP16, vectorial FP32 runs scalar
  assign lane1_active_o = vectorial_i && (fmt_i == FP16);

  // ----------------------------------------
  // Lane units
  // ----------------------------------------
  noncomp_lane #(
    .LaneWidth ( SLICE_WIDTH )
  ) u_lane0 (
    .a_i      ( operands_i[0]    ),
    .b_i      ( operands_i[1]    ),
    .op_i     ( op_i             ),
    .fmt_i    ( fmt_i            ),
    .result_o ( lane_result_o[0] ),
    .nv_o     ( lane_nv_o[0]     )
  );

  noncomp_lane #(
    .LaneWidth ( FP16_WIDTH )
  ) u_lane1 (
    .a_i      ( operands_i[0][SLICE_WIDTH-1 -: FP16_WIDTH] ),  // Upper halves
    .b_i      ( operands_i[1][SLICE_WIDTH-1 -: FP16_WIDTH] ),
    .op_i     ( op_i                                        ),
    .fmt_i    ( FP16                                        ),
    .result_o ( lane1_res                                   ),
    .nv_o     ( lane_nv_o[1]                                )
  );

  assign lane_result_o[1] = {{(SLICE_WIDTH-FP16_WIDTH){1'b0}}, lane1_res};

  // Side information travelling with the data
  assign aux_o   = {vectorial_i, fmt_i};
  assign tag_o   = tag_i;
  assign mask_o  = simd_mask_i;
  assign valid_o = in_valid_i;

  // Handshake must stay clean once out of reset
  assert property (@(posedge clk_i) disable iff (reset_i) !$isunknown(in_valid_i))
    else $error("in_valid_i is unknown");

endmodule

`default_nettype wire

//--- rtl/slice_pipe.sv
// Shared pipeline of the SIMD slice
// NumPipeRegs enable-register stages holding lane results, NV flags,
// tag and aux bits. Valid/ready handshake on both sides, synchronous
// flush of all stage valids. A stage advances when the next one is
// ready or empty. NumPipeRegs = 0 gives a combinational pass-through

`timescale 1ns/1ns
`default_nettype none

module slice_pipe import fp_slice_pkg::*; #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned TagWidth    = 4
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  flush_i,
  // Upstream side
  input  logic                                  in_valid_i,
  output logic                                  in_ready_o,
  input  logic [NUM_LANES-1:0][SLICE_WIDTH-1:0] lane_result_i,
  input  logic [NUM_LANES-1:0]                  lane_nv_i,
  input  logic                                  lane1_active_i,
  input  logic [AUX_BITS-1:0]                   aux_i,
  input  logic [TagWidth-1:0]                   tag_i,
  input  logic [NUM_LANES-1:0]                  mask_i,
  // Downstream side
  output logic                                  out_valid_o,
  input  logic                                  out_ready_i,
  output logic [NUM_LANES-1:0][SLICE_WIDTH-1:0] lane_result_o,
  output logic [NUM_LANES-1:0]                  lane_nv_o,
  output logic                                  lane1_active_o,
  output logic [AUX_BITS-1:0]                   aux_o,
  output logic [TagWidth-1:0]                   tag_o,
  output logic [NUM_LANES-1:0]                  mask_o,
  output logic                                  busy_o
);

  localparam int unsigned PayloadWidth =
      NUM_LANES*SLICE_WIDTH + NUM_LANES + 1 + AUX_BITS + TagWidth + NUM_LANES;

  // Index i is the signal after i register stages
  logic [PayloadWidth-1:0] stage_data  [0:NumPipeRegs];
  logic                    stage_valid [0:NumPipeRegs];
  logic                    stage_ready [0:NumPipeRegs];

  assign stage_data[0]  = {lane_result_i, lane_nv_i, lane1_active_i, aux_i, tag_i, mask_i};
  assign stage_valid[0] = in_valid_i;
  assign stage_ready[NumPipeRegs] = out_ready_i;  // Driven by the consumer

  // ----------------------------------------
  // Register stages
  // ----------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic                    valid_q;
    logic [PayloadWidth-1:0] data_q;

    // Advance if the next stage takes our item or holds only a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];

    always_ff @(posedge clk_i) begin
      if (reset_i || flush_i) begin
        valid_q <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q <= stage_valid[i];
      end
    end

    // Payload loads only when a valid item moves in
    always_ff @(posedge clk_i) begin
      if (stage_ready[i] && stage_valid[i]) begin
        data_q <= stage_data[i];
      end
    end

    assign stage_valid[i+1] = valid_q;
    assign stage_data[i+1]  = data_q;
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------
  assign in_ready_o  = stage_ready[0];
  assign out_valid_o = stage_valid[NumPipeRegs];
  assign {lane_result_o, lane_nv_o, lane1_active_o, aux_o, tag_o, mask_o} =
      stage_data[NumPipeRegs];

  if (NumPipeRegs == 0) begin : gen_busy_comb
    assign busy_o = in_valid_i;  // Item passes straight through
  end else begin : gen_busy_regs
    always_comb begin
      busy_o = 1'b0;
      for (int i = 1; i <= NumPipeRegs; i++) begin
        busy_o |= stage_valid[i];
      end
    end

    // Stalled output keeps its item until it is taken
    assert property (@(posedge clk_i) disable iff (reset_i)
        out_valid_o && !out_ready_i && !flush_i
        |=> out_valid_o && $stable(stage_data[NumPipeRegs]))
      else $error("Output changed while stalled");

    assert property (@(posedge clk_i) disable iff (reset_i) flush_i |=> !busy_o)
      else $error("Valid item left after flush");
  end

endmodule

`default_nettype wire

//--- rtl/result_pack.sv
// Result packer of the SIMD slice
// Assembles the 32-bit result from the lane results by format, NaN-boxes
// scalar FP16 results and collapses the lane NV flags under the SIMD mask

`timescale 1ns/1ns
`default_nettype none

module result_pack import fp_slice_pkg::*; (
  input  logic [NUM_LANES-1:0][SLICE_WIDTH-1:0] lane_result_i,
  input  logic [NUM_LANES-1:0]                  lane_nv_i,
  input  logic                                  lane1_active_i,
  input  logic [AUX_BITS-1:0]                   aux_i,
  input  logic [NUM_LANES-1:0]                  mask_i,
  output logic [SLICE_WIDTH-1:0]                result_o,
  output status_t                               status_o
);

  fp_format_e           res_fmt;
  logic                 res_vec;
  logic [NUM_LANES-1:0] lane_used;  // Lanes allowed to report status

  assign {res_vec, res_fmt} = aux_i;
  assign lane_used = {lane1_active_i, 1'b1};

  // ----------------------------------------
  // Result assembly
  // ----------------------------------------
  always_comb begin : pack
    if (res_fmt == FP32) begin
      result_o = lane_result_i[0];
    end else if (res_vec) begin
      result_o = {lane_result_i[1][FP16_WIDTH-1:0], lane_result_i[0][FP16_WIDTH-1:0]};
    end else begin
      // Scalar FP16, upper half boxed with ones
      result_o = {{(SLICE_WIDTH-FP16_WIDTH){1'b1}}, lane_result_i[0][FP16_WIDTH-1:0]};
    end
  end

  // ----------------------------------------
  // Status collapse
  // ----------------------------------------
  always_comb begin : collapse
    logic nv;
    nv = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      nv |= lane_nv_i[i] & mask_i[i] & lane_used[i];
    end
    status_o    = '0;
    status_o.NV = nv;
  end

endmodule

`default_nettype wire

//--- rtl/fp_noncomp_slice.sv
// Two-lane non-computational FP slice, top level
// Sign injection and min/max on one FP32 lane or two FP16 lanes.
// Issue stage and packer are combinational, all latency sits in the
// shared pipeline of NumPipeRegs stages

`timescale 1ns/1ns
`default_nettype none

module fp_noncomp_slice import fp_slice_pkg::*; #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned TagWidth    = 4
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // Operation
  input  logic [1:0][SLICE_WIDTH-1:0] operands_i,
  input  op_e                         op_i,
  input  fp_format_e                  fmt_i,
  input  logic                        vectorial_i,
  input  logic [NUM_LANES-1:0]        simd_mask_i,
  input  logic [TagWidth-1:0]         tag_i,
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  input  logic                        flush_i,
  // Result
  output logic [SLICE_WIDTH-1:0]      result_o,
  output status_t                     status_o,
  output logic [TagWidth-1:0]         tag_o,
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  output logic                        busy_o
);

  // Issue stage to pipeline
  logic [NUM_LANES-1:0][SLICE_WIDTH-1:0] iss_lane_result;
  logic [NUM_LANES-1:0]                  iss_lane_nv;
  logic                                  iss_lane1_active;
  logic [AUX_BITS-1:0]                   iss_aux;
  logic [TagWidth-1:0]                   iss_tag;
  logic [NUM_LANES-1:0]                  iss_mask;
  logic                                  iss_valid;

  // Pipeline to packer
  logic [NUM_LANES-1:0][SLICE_WIDTH-1:0] pip_lane_result;
  logic [NUM_LANES-1:0]                  pip_lane_nv;
  logic                                  pip_lane1_active;
  logic [AUX_BITS-1:0]                   pip_aux;
  logic [NUM_LANES-1:0]                  pip_mask;

  lane_issue #(
    .TagWidth ( TagWidth )
  ) u_issue (
    .clk_i, .reset_i,
    .operands_i, .op_i, .fmt_i, .vectorial_i, .simd_mask_i, .tag_i, .in_valid_i,
    .lane_result_o  ( iss_lane_result  ),
    .lane_nv_o      ( iss_lane_nv      ),
    .lane1_active_o ( iss_lane1_active ),
    .aux_o          ( iss_aux          ),
    .tag_o          ( iss_tag          ),
    .mask_o         ( iss_mask         ),
    .valid_o        ( iss_valid        )
  );

  slice_pipe #(
    .NumPipeRegs ( NumPipeRegs ),
    .TagWidth    ( TagWidth    )
  ) u_pipe (
    .clk_i, .reset_i, .flush_i,
    .in_valid_i     ( iss_valid        ),
    .in_ready_o,
    .lane_result_i  ( iss_lane_result  ),
    .lane_nv_i      ( iss_lane_nv      ),
    .lane1_active_i ( iss_lane1_active ),
    .aux_i          ( iss_aux          ),
    .tag_i          ( iss_tag          ),
    .mask_i         ( iss_mask         ),
    .out_valid_o, .out_ready_i,
    .lane_result_o  ( pip_lane_result  ),
    .lane_nv_o      ( pip_lane_nv      ),
    .lane1_active_o ( pip_lane1_active ),
    .aux_o          ( pip_aux          ),
    .tag_o,                              // Tag leaves straight from the last stage
    .mask_o         ( pip_mask         ),
    .busy_o
  );

  result_pack u_pack (
    .lane_result_i  ( pip_lane_result  ),
    .lane_nv_i      ( pip_lane_nv      ),
    .lane1_active_i ( pip_lane1_active ),
    .aux_i          ( pip_aux          ),
    .mask_i         ( pip_mask         ),
    .result_o,
    .status_o
  );

endmodule

`default_nettype wire

//--- tests/slice_checker.sv
// Scoreboard for the non-computational FP slice
// Holds expected results in issue order, compares result, status and tag
// at every output transfer, checks the latency at full throughput and
// the state of the pipeline after reset and after a flush

`timescale 1ns/1ns
`default_nettype none

module slice_checker import fp_slice_pkg::*; #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned TagWidth    = 4
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   flush_i,
  input  logic                   in_ready_i,
  input  logic                   out_valid_i,
  input  logic                   out_ready_i,
  input  logic                   busy_i,
  input  logic [SLICE_WIDTH-1:0] result_i,
  input  status_t                status_i,
  input  logic [TagWidth-1:0]    tag_i,
  output int                     error_count_o,
  output int                     pending_o
);

  // Expected items, oldest first
  string                  exp_name[$];
  logic [SLICE_WIDTH-1:0] exp_result[$];
  status_t                exp_status[$];
  logic [TagWidth-1:0]    exp_tag[$];
  int unsigned            exp_cycle[$];  // Edge of the input transfer

  int unsigned cycle        = 0;
  int unsigned last_stall   = 0;  // Last edge with out_ready low
  int          n_compared   = 0;
  int          n_flushed    = 0;
  int          n_mismatch   = 0;
  int          n_unexpected = 0;
  int          n_protocol   = 0;
  logic        reset_q      = 1'b0;
  logic        flush_q      = 1'b0;

  assign error_count_o = n_mismatch + n_unexpected + n_protocol;
  assign pending_o     = exp_name.size();

  // Called mid-cycle, the transfer happens at the coming edge
  task automatic expect_item(input string name, input logic [SLICE_WIDTH-1:0] result,
                             input status_t status, input logic [TagWidth-1:0] tag);
    exp_name.push_back(name);
    exp_result.push_back(result);
    exp_status.push_back(status);
    exp_tag.push_back(tag);
    exp_cycle.push_back(cycle + 1);
  endtask

  task automatic compare_output();
    string                  name;
    logic [SLICE_WIDTH-1:0] e_result;
    status_t                e_status;
    logic [TagWidth-1:0]    e_tag;
    int unsigned            e_cycle;
    if (exp_name.size() == 0) begin
      n_unexpected++;
      $display("Output %h with tag %h arrived while no operation was pending",
               result_i, tag_i);
    end else begin
      name     = exp_name.pop_front();
      e_result = exp_result.pop_front();
      e_status = exp_status.pop_front();
      e_tag    = exp_tag.pop_front();
      e_cycle  = exp_cycle.pop_front();
      n_compared++;
      if (result_i !== e_result) begin
        n_mismatch++;
        $display("Mismatch %s result: expected %h, actual %h", name, e_result, result_i);
      end
      if (status_i !== e_status) begin
        n_mismatch++;
        $display("Mismatch %s status: expected %h, actual %h", name, e_status, status_i);
      end
      if (tag_i !== e_tag) begin
        n_mismatch++;
        $display("Mismatch %s tag: expected %h, actual %h", name, e_tag, tag_i);
      end
      // Fixed latency only holds if the output never stalled meanwhile
      if (last_stall < e_cycle && cycle - e_cycle != NumPipeRegs) begin
        n_protocol++;
        $display("%s came out %0d cycles after it was accepted instead of %0d",
                 name, cycle - e_cycle, NumPipeRegs);
      end
    end
  endtask

  // ----------------------------------------
  // Output monitor
  // ----------------------------------------
  always @(posedge clk_i) begin
    cycle = cycle + 1;
    if (!out_ready_i) last_stall = cycle;
    if (reset_i) begin
      reset_q = 1'b1;
      flush_q = 1'b0;
    end else begin
      if (reset_q && (out_valid_i || busy_i || !in_ready_i)) begin
        n_protocol++;
        $display("Pipeline not idle after reset: out_valid %b, busy %b, in_ready %b",
                 out_valid_i, busy_i, in_ready_i);
      end
      if (flush_q && (out_valid_i || busy_i)) begin
        n_protocol++;
        $display("Items still present after flush: out_valid %b, busy %b",
                 out_valid_i, busy_i);
      end
      if (out_valid_i && out_ready_i) compare_output();
      if (flush_i && NumPipeRegs != 0) begin  // Everything in flight is dropped
        n_flushed += exp_name.size();
        exp_name.delete();
        exp_result.delete();
        exp_status.delete();
        exp_tag.delete();
        exp_cycle.delete();
      end
      reset_q = 1'b0;
      flush_q = flush_i && (NumPipeRegs != 0);
    end
  end

  task automatic print_summary();
    $display("Checker: %0d compared, %0d flushed, %0d mismatches, %0d unexpected, %0d other errors",
             n_compared, n_flushed, n_mismatch, n_unexpected, n_protocol);
  endtask

endmodule

`default_nettype wire

//--- tests/tb_fp_noncomp_slice.sv
// Testbench for the two-lane non-computational FP slice
// Applies a table of sign-injection and min/max cases under random
// back-pressure, flushes a full pipeline, then repeats the table at
// full throughput. slice_checker does all the comparing

`timescale 1ns/1ns
`default_nettype none

module tb_fp_noncomp_slice import fp_slice_pkg::*; ();

  localparam int unsigned NumPipeRegs = 2;
  localparam int unsigned TagWidth    = 4;
  localparam logic [31:0] Seed        = 32'hd06b7fe8;

  // Output ready modes
  localparam int ReadyRandom = 0;
  localparam int ReadyHigh   = 1;
  localparam int ReadyLow    = 2;

  logic                        clk = 1'b0;
  logic                        reset;
  logic [1:0][SLICE_WIDTH-1:0] operands;  // {b, a}
  op_e                         op;
  fp_format_e                  fmt;
  logic                        vectorial;
  logic [NUM_LANES-1:0]        simd_mask;
  logic [TagWidth-1:0]         tag;
  logic                        in_valid;
  logic                        in_ready;
  logic                        flush;
  logic [SLICE_WIDTH-1:0]      result;
  status_t                     status;
  logic [TagWidth-1:0]         tag_out;
  logic                        out_valid;
  logic                        out_ready;
  logic                        busy;
  int                          error_count;
  int                          pending;
  int                          ready_mode  = ReadyLow;
  logic [31:0]                 rng_state;
  logic                        table_ready = 1'b0;

  // Stimulus table
  string                  tbl_name[$];
  op_e                    tbl_op[$];
  fp_format_e             tbl_fmt[$];
  logic                   tbl_vec[$];
  logic [NUM_LANES-1:0]   tbl_mask[$];
  logic [SLICE_WIDTH-1:0] tbl_a[$];
  logic [SLICE_WIDTH-1:0] tbl_b[$];
  logic [SLICE_WIDTH-1:0] tbl_res[$];
  logic                   tbl_nv[$];

  fp_noncomp_slice #(
    .NumPipeRegs ( NumPipeRegs ),
    .TagWidth    ( TagWidth    )
  ) DUT (
    .clk_i       ( clk       ),
    .reset_i     ( reset     ),
    .operands_i  ( operands  ),
    .op_i        ( op        ),
    .fmt_i       ( fmt       ),
    .vectorial_i ( vectorial ),
    .simd_mask_i ( simd_mask ),
    .tag_i       ( tag       ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .flush_i     ( flush     ),
    .result_o    ( result    ),
    .status_o    ( status    ),
    .tag_o       ( tag_out   ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .busy_o      ( busy      )
  );

  slice_checker #(
    .NumPipeRegs ( NumPipeRegs ),
    .TagWidth    ( TagWidth    )
  ) u_checker (
    .clk_i         ( clk         ),
    .reset_i       ( reset       ),
    .flush_i       ( flush       ),
    .in_ready_i    ( in_ready    ),
    .out_valid_i   ( out_valid   ),
    .out_ready_i   ( out_ready   ),
    .busy_i        ( busy        ),
    .result_i      ( result      ),
    .status_i      ( status      ),
    .tag_i         ( tag_out     ),
    .error_count_o ( error_count ),
    .pending_o     ( pending     )
  );

  always #4 clk = ~clk;  // 8 ns period

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic add_entry(input string name, input op_e e_op, input fp_format_e e_fmt,
                           input logic vec, input logic [NUM_LANES-1:0] mask,
                           input logic [SLICE_WIDTH-1:0] a, input logic [SLICE_WIDTH-1:0] b,
                           input logic [SLICE_WIDTH-1:0] res, input logic nv);
    tbl_name.push_back(name);
    tbl_op.push_back(e_op);
    tbl_fmt.push_back(e_fmt);
    tbl_vec.push_back(vec);
    tbl_mask.push_back(mask);
    tbl_a.push_back(a);
    tbl_b.push_back(b);
    tbl_res.push_back(res);
    tbl_nv.push_back(nv);
  endtask

  // ----------------------------------------
  // Test cases
  // ----------------------------------------
  task automatic load_table();
    // Sign injection never raises NV
    add_entry("sgnj_fp32", OP_SGNJ, FP32, 1'b0, 2'b01,
              32'h3F80_0000, 32'hC000_0000, 32'hBF80_0000, 1'b0);
    add_entry("sgnjn_fp32", OP_SGNJN, FP32, 1'b0, 2'b01,
              32'hBF80_0000, 32'hC000_0000, 32'h3F80_0000, 1'b0);
    add_entry("sgnjx_fp32", OP_SGNJX, FP32, 1'b0, 2'b01,
              32'h3FC0_0000, 32'hC040_0000, 32'hBFC0_0000, 1'b0);
    add_entry("sgnj_snan_fp32", OP_SGNJ, FP32, 1'b0, 2'b11,
              32'h7F80_0001, 32'h8000_0000, 32'hFF80_0001, 1'b0);
    // FP16 packing and boxing
    add_entry("sgnj_fp16_boxed", OP_SGNJ, FP16, 1'b0, 2'b01,
              32'h1234_3C00, 32'h5678_C000, 32'hFFFF_BC00, 1'b0);
    add_entry("sgnjn_fp16_vec", OP_SGNJN, FP16, 1'b1, 2'b11,
              32'h4000_3C00, 32'h8000_0000, 32'h4000_BC00, 1'b0);
    add_entry("sgnjx_fp32_vec", OP_SGNJX, FP32, 1'b1, 2'b11,  // Runs as scalar
              32'h4049_0FDB, 32'h8000_0000, 32'hC049_0FDB, 1'b0);
    add_entry("max_fp16_vec", OP_MAX, FP16, 1'b1, 2'b11,
              32'hC400_3C00, 32'h4200_BC00, 32'h4200_3C00, 1'b0);
    // Ordering
    add_entry("min_zero_fp32", OP_MIN, FP32, 1'b0, 2'b01,
              32'h0000_0000, 32'h8000_0000, 32'h8000_0000, 1'b0);
    add_entry("max_zero_fp32", OP_MAX, FP32, 1'b0, 2'b01,
              32'h8000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0);
    add_entry("min_neg_fp32", OP_MIN, FP32, 1'b0, 2'b01,
              32'hC040_0000, 32'hC000_0000, 32'hC040_0000, 1'b0);
    add_entry("max_pos_fp32", OP_MAX, FP32, 1'b0, 2'b01,
              32'h3F80_0000, 32'h4000_0000, 32'h4000_0000, 1'b0);
    // NaN handling
    add_entry("min_qnan_fp32", OP_MIN, FP32, 1'b0, 2'b01,
              32'h7FC0_0000, 32'h40A0_0000, 32'h40A0_0000, 1'b0);
    add_entry("max_two_nan_fp32", OP_MAX, FP32, 1'b0, 2'b01,
              32'h7FE0_0000, 32'hFFC1_2345, 32'h7FC0_0000, 1'b0);
    add_entry("min_snan_fp32", OP_MIN, FP32, 1'b0, 2'b01,
              32'h7F80_0001, 32'h3F80_0000, 32'h3F80_0000, 1'b1);
    add_entry("min_snan_masked", OP_MIN, FP32, 1'b0, 2'b10,
              32'h7F80_0001, 32'h3F80_0000, 32'h3F80_0000, 1'b0);
    add_entry("min_snan_fp16", OP_MIN, FP16, 1'b0, 2'b01,  // NaN in b
              32'h0000_3C00, 32'h0000_7C01, 32'hFFFF_3C00, 1'b1);
    add_entry("min_snan_lane1", OP_MIN, FP16, 1'b1, 2'b10,
              32'h7C01_3C00, 32'h3C00_4000, 32'h3C00_3C00, 1'b1);
    add_entry("min_snan_lane1_masked", OP_MIN, FP16, 1'b1, 2'b01,
              32'h7C01_3C00, 32'h3C00_4000, 32'h3C00_3C00, 1'b0);
    add_entry("min_snan_upper_scalar", OP_MIN, FP16, 1'b0, 2'b11,  // Lane 1 idle
              32'h7C01_3C00, 32'h3C00_4000, 32'hFFFF_3C00, 1'b0);
    add_entry("max_two_nan_fp16", OP_MAX, FP16, 1'b0, 2'b01,
              32'h0000_7E01, 32'h0000_7C01, 32'hFFFF_7E00, 1'b1);
    add_entry("min_zero_fp16_vec", OP_MIN, FP16, 1'b1, 2'b11,
              32'h8000_0000, 32'h0000_8000, 32'h8000_8000, 1'b0);
  endtask

  // Presents one entry and holds it until the slice accepts it
  task automatic issue_entry(input int idx);
    logic accepted;
    operands  = {tbl_b[idx], tbl_a[idx]};
    op        = tbl_op[idx];
    fmt       = tbl_fmt[idx];
    vectorial = tbl_vec[idx];
    simd_mask = tbl_mask[idx];
    in_valid  = 1'b1;
    accepted  = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_ready;  // Transfer at the next rising edge
      if (accepted) begin
        u_checker.expect_item(tbl_name[idx], tbl_res[idx], {tbl_nv[idx], 4'b0000}, tag);
      end
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
    tag      = tag + 1'b1;
  endtask

  task automatic wait_drained();
    while (pending != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  // Output ready changes 1 ns after each rising edge
  initial begin : ready_driver
    out_ready = 1'b0;
    rng_state = Seed;
    forever begin
      @(posedge clk);
      #1;
      rng_state = xorshift32(rng_state);
      case (ready_mode)
        ReadyRandom: out_ready = rng_state[7];
        ReadyHigh:   out_ready = 1'b1;
        default:     out_ready = 1'b0;
      endcase
    end
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin : main
    reset     = 1'b1;
    operands  = '0;
    op        = OP_SGNJ;
    fmt       = FP32;
    vectorial = 1'b0;
    simd_mask = '0;
    tag       = '0;
    in_valid  = 1'b0;
    flush     = 1'b0;
    load_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    ready_mode = ReadyRandom;  // Random back-pressure
    repeat (2) @(posedge clk);
    #1;
    for (int i = 0; i < tbl_name.size(); i++) begin
      issue_entry(i);
    end
    wait_drained();

    if (NumPipeRegs != 0) begin
      ready_mode = ReadyLow;  // Fill every stage, then flush
      repeat (2) @(posedge clk);
      #1;
      for (int i = 0; i < NumPipeRegs; i++) begin
        issue_entry(i);
      end
      flush = 1'b1;
      @(posedge clk);
      #1;
      flush = 1'b0;
    end

    ready_mode = ReadyHigh;  // Full throughput with fixed latency
    repeat (2) @(posedge clk);
    #1;
    for (int i = 0; i < tbl_name.size(); i++) begin
      issue_entry(i);
    end
    wait_drained();
    repeat (4) @(posedge clk);

    u_checker.print_summary();
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog budget scales with the table length
  initial begin : watchdog
    int unsigned limit;
    wait (table_ready);
    limit = tbl_name.size() * (NumPipeRegs + 8) + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- fp_noncomp_slice.f
rtl/fp_slice_pkg.sv
rtl/noncomp_lane.sv
rtl/lane_issue.sv
rtl/slice_pipe.sv
rtl/result_pack.sv
rtl/fp_noncomp_slice.sv
tests/slice_checker.sv
tests/tb_fp_noncomp_slice.sv

//--- Makefile
# Verilator build and run for the non-computational FP slice

TOP := tb_fp_noncomp_slice

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f fp_noncomp_slice.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
